/* x300_radio_slots.f */
design/x300_radio_pkg.sv
design/atr_gpio_ctrl.sv
design/db_control.sv
design/fe_iq_map.sv
design/x300_radio_slots.sv
bench/x300_radio_slots_tb.sv

/* bench/x300_radio_slots_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module x300_radio_slots_tb
   import x300_radio_pkg::*;
();

   localparam int CLK_PERIOD       = 100;
   localparam int RESET_CYCLES     = 16;
   localparam int RUN_N            = 13;   // run-flag table
   localparam int MAP_N            = 8;    // every mapping value
   localparam int FE_N             = NUM_DBOARDS * 3;   // rx0, rx1, tx0 per slot
   localparam int FS_N             = 6;    // full-scale samples
   localparam int SAMP_N           = 16;   // samples per mapping
   localparam int REG_N            = 5;
   localparam int RB_N             = 6;
   localparam int CYCLES_PER_ENTRY = 8;
   localparam int NUM_ENTRIES      = 2 * NUM_DBOARDS * ATR_NUM_WORDS + RUN_N
                                   + MAP_N * (FE_N + SAMP_N) + REG_N + NUM_DBOARDS * (RB_N + 1);
   localparam int WATCHDOG_CYCLES  = RESET_CYCLES + NUM_ENTRIES * CYCLES_PER_ENTRY;

   logic                  radio_clk;
   logic                  i_rst;
   logic [SAMP_W-1:0]     i_rx0;
   logic [SAMP_W-1:0]     i_rx1;
   logic [SAMP_W-1:0]     i_tx_data     [NUM_DBOARDS];
   logic [SAMP_W-1:0]     o_tx0;
   logic [SAMP_W-1:0]     o_tx1;
   logic [SAMP_W-1:0]     o_rx_data     [NUM_CHANNELS];
   logic                  i_rx_running  [NUM_CHANNELS];
   logic                  i_tx_running  [NUM_CHANNELS];
   logic                  i_set_stb     [NUM_DBOARDS];
   logic [SET_ADDR_W-1:0] i_set_addr    [NUM_DBOARDS];
   logic [SET_DATA_W-1:0] i_set_data    [NUM_DBOARDS];
   logic                  i_rb_stb      [NUM_DBOARDS];
   logic [SET_ADDR_W-1:0] i_rb_addr     [NUM_DBOARDS];
   logic                  o_rb_stb      [NUM_DBOARDS];
   logic [RB_DATA_W-1:0]  o_rb_data     [NUM_DBOARDS];
   logic [SAMP_W-1:0]     i_db_gpio_in  [NUM_DBOARDS];
   logic [SAMP_W-1:0]     o_db_gpio_out [NUM_DBOARDS];
   logic [SAMP_W-1:0]     o_db_gpio_ddr [NUM_DBOARDS];
   logic [LED_W-1:0]      o_radio_led   [NUM_DBOARDS];
   logic [SAMP_W-1:0]     i_misc_in     [NUM_DBOARDS];
   logic [SAMP_W-1:0]     o_misc_out    [NUM_DBOARDS];

   // model state
   logic [31:0]           lcg_state;
   int                    n_checks;
   int                    n_errors;
   logic [SAMP_W-1:0]     gpio_atr_w [NUM_DBOARDS][ATR_NUM_WORDS];
   logic [SAMP_W-1:0]     led_atr_w  [NUM_DBOARDS][ATR_NUM_WORDS];
   logic [SAMP_W-1:0]     exp_misc   [NUM_DBOARDS];
   logic [SAMP_W-1:0]     exp_ddr    [NUM_DBOARDS];
   logic [1:0]            exp_state  [NUM_DBOARDS];
   logic [2:0]            map_val    [FE_N];       // ch = slot*3 + {rx0, rx1, tx0}
   logic [11:0]           run_tab    [RUN_N];      // {rx[3:0], tx[3:0], st1, st0}
   logic [1:0]            reg_tab    [REG_N];      // {ddr not misc, slot}
   logic [SET_ADDR_W-1:0] rb_tab     [RB_N];
   logic [SAMP_W-1:0]     fs_tab     [FS_N];

   x300_radio_slots DUT (
      .radio_clk     (radio_clk),
      .i_rst         (i_rst),
      .i_rx0         (i_rx0),
      .i_rx1         (i_rx1),
      .i_tx_data     (i_tx_data),
      .o_tx0         (o_tx0),
      .o_tx1         (o_tx1),
      .o_rx_data     (o_rx_data),
      .i_rx_running  (i_rx_running),
      .i_tx_running  (i_tx_running),
      .i_set_stb     (i_set_stb),
      .i_set_addr    (i_set_addr),
      .i_set_data    (i_set_data),
      .i_rb_stb      (i_rb_stb),
      .i_rb_addr     (i_rb_addr),
      .o_rb_stb      (o_rb_stb),
      .o_rb_data     (o_rb_data),
      .i_db_gpio_in  (i_db_gpio_in),
      .o_db_gpio_out (o_db_gpio_out),
      .o_db_gpio_ddr (o_db_gpio_ddr),
      .o_radio_led   (o_radio_led),
      .i_misc_in     (i_misc_in),
      .o_misc_out    (o_misc_out)
   );

   initial
   begin
      radio_clk = 1'b0;
      forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
   end

   // ----------------------------------------
   // random numbers and models
   // ----------------------------------------
   function automatic logic [15:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:15];   // low bits of an lcg are weak
   endfunction

   function automatic logic [31:0] rand32();
      logic [15:0] hi;
      hi = lcg_next();
      return {hi, lcg_next()};
   endfunction

   // two's complement negate, -32768 clamps to +32767
   function automatic logic [COMP_W-1:0] neg_sat(input logic [COMP_W-1:0] c);
      int v;
      v = $signed(c);
      v = -v;
      if (v > 32767)
         v = 32767;
      return v[COMP_W-1:0];
   endfunction

   function automatic logic [SAMP_W-1:0] fe_model(input logic [2:0] m,
                                                  input logic [SAMP_W-1:0] x);
      logic [COMP_W-1:0] ci;
      logic [COMP_W-1:0] cq;
      ci = x[31:16];
      cq = x[15:0];
      if (m[0])   // swap first
      begin
         ci = x[15:0];
         cq = x[31:16];
      end
      if (m[1])
         ci = neg_sat(ci);
      if (m[2])
         cq = neg_sat(cq);
      return {ci, cq};
   endfunction

   function automatic logic [RB_DATA_W-1:0] rb_model(input int s, input logic [SET_ADDR_W-1:0] a);
      case (a)
         8'd16:   return {32'd0, i_misc_in[s]};          // misc in
         8'd17:   return {exp_ddr[s], i_db_gpio_in[s]};  // ddr, gpio in
         8'd18:   return {62'd0, exp_state[s]};          // atr state
         default: return '0;
      endcase
   endfunction

   function automatic logic [SET_ADDR_W-1:0] fe_addr(input int kind);
      if (kind == 0)
         return SR_RX_FE_BASE;
      else if (kind == 1)
         return SR_RX_FE_BASE + SR_FE_CHAN_OFFSET;
      return SR_TX_FE_BASE;
   endfunction

   // ----------------------------------------
   // checks and bus tasks
   // ----------------------------------------
   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      n_checks++;
      if (act !== exp)
      begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   // called right after a falling edge, returns one edge later
   task automatic write_reg(input int s, input logic [SET_ADDR_W-1:0] a, input logic [31:0] d);
      i_set_stb[s]  = 1'b1;
      i_set_addr[s] = a;
      i_set_data[s] = d;
      @(negedge radio_clk);
      i_set_stb[s]  = 1'b0;
   endtask

   task automatic read_back(input int s, input logic [SET_ADDR_W-1:0] a,
                            input logic [RB_DATA_W-1:0] exp);
      check($sformatf("o_rb_stb[%0d] before request", s), 0, o_rb_stb[s]);
      i_rb_stb[s]  = 1'b1;
      i_rb_addr[s] = a;
      @(negedge radio_clk);
      i_rb_stb[s]  = 1'b0;
      i_rb_addr[s] = '0;
      check($sformatf("o_rb_stb[%0d]", s), 1, o_rb_stb[s]);
      check($sformatf("o_rb_data[%0d] addr %0d", s, a), exp, o_rb_data[s]);
      @(negedge radio_clk);
      check($sformatf("o_rb_stb[%0d] after pulse", s), 0, o_rb_stb[s]);
      check($sformatf("o_rb_data[%0d] held", s), exp, o_rb_data[s]);
   endtask

   task automatic check_zero_outputs();
      check("o_tx0", 0, o_tx0);
      check("o_tx1", 0, o_tx1);
      for (int c = 0; c < NUM_CHANNELS; c++)
         check($sformatf("o_rx_data[%0d]", c), 0, o_rx_data[c]);
      for (int s = 0; s < NUM_DBOARDS; s++)
      begin
         check($sformatf("o_rb_stb[%0d]", s), 0, o_rb_stb[s]);
         check($sformatf("o_rb_data[%0d]", s), 0, o_rb_data[s]);
         check($sformatf("o_db_gpio_out[%0d]", s), 0, o_db_gpio_out[s]);
         check($sformatf("o_db_gpio_ddr[%0d]", s), 0, o_db_gpio_ddr[s]);
         check($sformatf("o_radio_led[%0d]", s), 0, o_radio_led[s]);
         check($sformatf("o_misc_out[%0d]", s), 0, o_misc_out[s]);
      end
   endtask

   task automatic check_atr(input int s, input logic [1:0] st);
      check($sformatf("o_db_gpio_out[%0d]", s), gpio_atr_w[s][st], o_db_gpio_out[s]);
      check($sformatf("o_radio_led[%0d]", s), led_atr_w[s][st][LED_W-1:0], o_radio_led[s]);
   endtask

   task automatic check_misc_ddr();
      for (int s = 0; s < NUM_DBOARDS; s++)
      begin
         check($sformatf("o_misc_out[%0d]", s), exp_misc[s], o_misc_out[s]);
         check($sformatf("o_db_gpio_ddr[%0d]", s), exp_ddr[s], o_db_gpio_ddr[s]);
      end
   endtask

   task automatic check_fe();
      logic [SAMP_W-1:0] adc;
      for (int s = 0; s < NUM_DBOARDS; s++)
      begin
         adc = (s == 0) ? i_rx0 : i_rx1;   // both rx channels share it
         for (int j = 0; j < 2; j++)
            check($sformatf("o_rx_data[%0d] map %0d", s*2 + j, map_val[s*3 + j]),
                  fe_model(map_val[s*3 + j], adc), o_rx_data[s*2 + j]);
      end
      check("o_tx0", fe_model(map_val[2], i_tx_data[0]), o_tx0);
      check("o_tx1", fe_model(map_val[5], i_tx_data[1]), o_tx1);
   endtask

   task automatic load_tables();
      // slot 0 is channels 0 and 1, slot 1 is channels 2 and 3
      run_tab[0]  = {4'b0000, 4'b0000, ATR_IDLE, ATR_IDLE};
      run_tab[1]  = {4'b0001, 4'b0000, ATR_IDLE, ATR_RX};
      run_tab[2]  = {4'b0010, 4'b0000, ATR_IDLE, ATR_RX};    // channel 1 alone
      run_tab[3]  = {4'b0010, 4'b0001, ATR_IDLE, ATR_FDX};
      run_tab[4]  = {4'b0000, 4'b0010, ATR_IDLE, ATR_TX};
      run_tab[5]  = {4'b0100, 4'b0000, ATR_RX,   ATR_IDLE};
      run_tab[6]  = {4'b1000, 4'b1000, ATR_FDX,  ATR_IDLE};
      run_tab[7]  = {4'b0011, 4'b0100, ATR_TX,   ATR_RX};
      run_tab[8]  = {4'b0000, 4'b1000, ATR_TX,   ATR_IDLE};
      run_tab[9]  = {4'b1111, 4'b1111, ATR_FDX,  ATR_FDX};
      run_tab[10] = {4'b0000, 4'b0011, ATR_IDLE, ATR_TX};
      run_tab[11] = {4'b0101, 4'b0010, ATR_RX,   ATR_FDX};
      run_tab[12] = {4'b0000, 4'b0000, ATR_IDLE, ATR_IDLE};
      reg_tab[0] = 2'b00;   // slot 0 misc
      reg_tab[1] = 2'b11;   // slot 1 ddr
      reg_tab[2] = 2'b01;
      reg_tab[3] = 2'b10;
      reg_tab[4] = 2'b00;
      rb_tab[0] = RB_MISC_IN;
      rb_tab[1] = RB_GPIO;
      rb_tab[2] = RB_ATR;
      rb_tab[3] = 8'd19;    // unused
      rb_tab[4] = 8'd0;
      rb_tab[5] = 8'd255;
      fs_tab[0] = 32'h8000_8000;
      fs_tab[1] = 32'h7fff_7fff;
      fs_tab[2] = 32'h8000_7fff;
      fs_tab[3] = 32'h7fff_8000;
      fs_tab[4] = 32'h0000_0000;
      fs_tab[5] = 32'hffff_0001;
   endtask

   // ----------------------------------------
   // stimulus
   // ----------------------------------------
   initial
   begin
      logic [31:0] data;
      logic [11:0] ent;
      int          s;
      lcg_state = 32'd19173;
      n_checks  = 0;
      n_errors  = 0;
      load_tables();
      i_rst = 1'b1;
      i_rx0 = rand32();   // busy inputs during reset
      i_rx1 = rand32();
      for (int k = 0; k < NUM_DBOARDS; k++)
      begin
         i_tx_data[k]    = rand32();
         i_set_stb[k]    = 1'b0;
         i_set_addr[k]   = '0;
         i_set_data[k]   = '0;
         i_rb_stb[k]     = 1'b0;
         i_rb_addr[k]    = '0;
         i_db_gpio_in[k] = '0;
         i_misc_in[k]    = '0;
         exp_misc[k]     = '0;
         exp_ddr[k]      = '0;
         exp_state[k]    = ATR_IDLE;
      end
      for (int c = 0; c < NUM_CHANNELS; c++)
      begin
         i_rx_running[c] = 1'b0;
         i_tx_running[c] = 1'b0;
      end
      repeat (RESET_CYCLES) @(negedge radio_clk);
      i_rst = 1'b0;
      i_rx0 = '0;
      i_rx1 = '0;
      for (int k = 0; k < NUM_DBOARDS; k++)
         i_tx_data[k] = '0;
      check_zero_outputs();
      for (int k = 0; k < NUM_DBOARDS; k++)
         read_back(k, RB_ATR, {62'd0, ATR_IDLE});

      // atr words, idle word last so its 2-cycle latency shows
      for (s = 0; s < NUM_DBOARDS; s++)
      begin
         for (int k = ATR_NUM_WORDS - 1; k >= 0; k--)
         begin
            data = rand32();
            data[LED_W-1:0] = s * ATR_NUM_WORDS + k;   // distinct pin pattern
            led_atr_w[s][k] = data;
            write_reg(s, SR_DB_BASE + SR_LED_ATR + k, data);
         end
         for (int k = ATR_NUM_WORDS - 1; k >= 0; k--)
         begin
            gpio_atr_w[s][k] = rand32();
            write_reg(s, SR_DB_BASE + SR_GPIO_ATR + k, gpio_atr_w[s][k]);
         end
         check($sformatf("o_db_gpio_out[%0d] 1 cycle after write", s), 0, o_db_gpio_out[s]);
         @(negedge radio_clk);
         check_atr(s, ATR_IDLE);
      end

      // run-flag table
      for (int e = 0; e < RUN_N; e++)
      begin
         ent = run_tab[e];
         for (int c = 0; c < NUM_CHANNELS; c++)
         begin
            i_rx_running[c] = ent[8 + c];
            i_tx_running[c] = ent[4 + c];
         end
         @(negedge radio_clk);
         check_atr(0, ent[1:0]);
         check_atr(1, ent[3:2]);
      end

      // front-end mapping, every channel gets its own value
      for (int m = 0; m < MAP_N; m++)
      begin
         for (int ch = 0; ch < FE_N; ch++)
         begin
            map_val[ch] = m + ch;
            data = rand32();
            data[2:0] = map_val[ch];   // upper bits are ignored
            write_reg(ch / 3, fe_addr(ch % 3), data);
         end
         for (int n = 0; n < SAMP_N; n++)
         begin
            if (n < FS_N)
            begin
               i_rx0        = fs_tab[n];
               i_rx1        = fs_tab[(n + 1) % FS_N];
               i_tx_data[0] = fs_tab[(n + 2) % FS_N];
               i_tx_data[1] = fs_tab[(n + 3) % FS_N];
            end
            else
            begin
               i_rx0        = rand32();
               i_rx1        = rand32();
               i_tx_data[0] = rand32();
               i_tx_data[1] = rand32();
            end
            @(negedge radio_clk);
            check_fe();
         end
      end

      // misc out and ddr
      for (int e = 0; e < REG_N; e++)
      begin
         s    = reg_tab[e][0];
         data = rand32();
         if (reg_tab[e][1])
         begin
            write_reg(s, SR_DB_BASE + SR_GPIO_DDR, data);
            exp_ddr[s] = data;
            check_misc_ddr();
         end
         else
         begin
            write_reg(s, SR_DB_BASE + SR_MISC_OUT, data);
            check_misc_ddr();   // still the old word
            exp_misc[s] = data;
            @(negedge radio_clk);
            check_misc_ddr();
         end
      end

      // readback, slot 0 rx only, slot 1 full duplex
      for (int k = 0; k < NUM_DBOARDS; k++)
      begin
         i_misc_in[k]    = rand32();
         i_db_gpio_in[k] = rand32();
      end
      i_rx_running[0] = 1'b1;
      i_rx_running[3] = 1'b1;
      i_tx_running[2] = 1'b1;
      exp_state[0] = ATR_RX;
      exp_state[1] = ATR_FDX;
      repeat (2) @(negedge radio_clk);   // misc in is registered
      for (int e = 0; e < RB_N; e++)
         for (int k = 0; k < NUM_DBOARDS; k++)
            read_back(k, rb_tab[e], rb_model(k, rb_tab[e]));

      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   // watchdog
   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* design/x300_radio_slots.sv */
`timescale 1ns/1ps
`default_nettype none

module x300_radio_slots
   import x300_radio_pkg::*;
(
   input  wire                   radio_clk,
   input  wire                   i_rst,
   // adc / dac words
   input  wire  [SAMP_W-1:0]     i_rx0,
   input  wire  [SAMP_W-1:0]     i_rx1,
   input  wire  [SAMP_W-1:0]     i_tx_data    [NUM_DBOARDS],   // channel 0 of each slot
   output logic [SAMP_W-1:0]     o_tx0,
   output logic [SAMP_W-1:0]     o_tx1,
   output logic [SAMP_W-1:0]     o_rx_data    [NUM_CHANNELS],
   // run levels per channel
   input  wire                   i_rx_running [NUM_CHANNELS],
   input  wire                   i_tx_running [NUM_CHANNELS],
   // settings bus per slot
   input  wire                   i_set_stb    [NUM_DBOARDS],
   input  wire  [SET_ADDR_W-1:0] i_set_addr   [NUM_DBOARDS],
   input  wire  [SET_DATA_W-1:0] i_set_data   [NUM_DBOARDS],
   // readback bus per slot
   input  wire                   i_rb_stb     [NUM_DBOARDS],
   input  wire  [SET_ADDR_W-1:0] i_rb_addr    [NUM_DBOARDS],
   output logic                  o_rb_stb     [NUM_DBOARDS],
   output logic [RB_DATA_W-1:0]  o_rb_data    [NUM_DBOARDS],
   // daughterboard io
   input  wire  [SAMP_W-1:0]     i_db_gpio_in [NUM_DBOARDS],
   output logic [SAMP_W-1:0]     o_db_gpio_out[NUM_DBOARDS],
   output logic [SAMP_W-1:0]     o_db_gpio_ddr[NUM_DBOARDS],
   output logic [LED_W-1:0]      o_radio_led  [NUM_DBOARDS],
   input  wire  [SAMP_W-1:0]     i_misc_in    [NUM_DBOARDS],
   output logic [SAMP_W-1:0]     o_misc_out   [NUM_DBOARDS]
);

   logic [SAMP_W-1:0] adc_word [NUM_DBOARDS];
   logic [SAMP_W-1:0] dac_word [NUM_DBOARDS];
   logic              run_rx   [NUM_DBOARDS];   // any channel of the slot
   logic              run_tx   [NUM_DBOARDS];

   // ----------------------------------------
   // adc / dac mapping
   // ----------------------------------------
   assign adc_word[0] = i_rx0;
   assign adc_word[1] = i_rx1;
   assign o_tx0       = dac_word[0];
   assign o_tx1       = dac_word[1];

   // one atr state per slot, so channel flags are merged
   always_comb
   begin
      for (int s = 0; s < NUM_DBOARDS; s++)
      begin
         run_rx[s] = 1'b0;
         run_tx[s] = 1'b0;
         for (int c = 0; c < NUM_CHANNELS_PER_DBOARD; c++)
         begin
            run_rx[s] = run_rx[s] | i_rx_running[s*NUM_CHANNELS_PER_DBOARD + c];
            run_tx[s] = run_tx[s] | i_tx_running[s*NUM_CHANNELS_PER_DBOARD + c];
         end
      end
   end

   // ----------------------------------------
   // per-slot blocks
   // ----------------------------------------
   for (genvar i = 0; i < NUM_DBOARDS; i++)
   begin : g_slot
      db_control u_db_control (
         .radio_clk     (radio_clk),
         .i_rst         (i_rst),
         .i_set_stb     (i_set_stb[i]),
         .i_set_addr    (i_set_addr[i]),
         .i_set_data    (i_set_data[i]),
         .i_rb_stb      (i_rb_stb[i]),
         .i_rb_addr     (i_rb_addr[i]),
         .o_rb_stb      (o_rb_stb[i]),
         .o_rb_data     (o_rb_data[i]),
         .i_run_rx      (run_rx[i]),
         .i_run_tx      (run_tx[i]),
         .i_db_gpio_in  (i_db_gpio_in[i]),
         .o_db_gpio_out (o_db_gpio_out[i]),
         .o_db_gpio_ddr (o_db_gpio_ddr[i]),
         .o_leds        (o_radio_led[i]),
         .i_misc_in     (i_misc_in[i]),
         .o_misc_out    (o_misc_out[i])
      );

      // both rx channels share the slot's adc word
      for (genvar j = 0; j < NUM_CHANNELS_PER_DBOARD; j++)
      begin : g_rx
         localparam logic [SET_ADDR_W-1:0] RX_ADDR = SR_RX_FE_BASE + j * SR_FE_CHAN_OFFSET;

         fe_iq_map #(
            .SR_ADDR    (RX_ADDR)
         ) u_rx_fe (
            .radio_clk  (radio_clk),
            .i_rst      (i_rst),
            .i_set_stb  (i_set_stb[i]),
            .i_set_addr (i_set_addr[i]),
            .i_set_data (i_set_data[i]),
            .i_sample   (adc_word[i]),
            .o_sample   (o_rx_data[i*NUM_CHANNELS_PER_DBOARD + j])
         );
      end

      // tx channel 0 only, it owns the dac
      fe_iq_map #(
         .SR_ADDR    (SR_TX_FE_BASE)
      ) u_tx_fe (
         .radio_clk  (radio_clk),
         .i_rst      (i_rst),
         .i_set_stb  (i_set_stb[i]),
         .i_set_addr (i_set_addr[i]),
         .i_set_data (i_set_data[i]),
         .i_sample   (i_tx_data[i]),
         .o_sample   (dac_word[i])
      );
   end

endmodule

`default_nettype wire

/* design/fe_iq_map.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_iq_map
   import x300_radio_pkg::*;
#(
   parameter logic [SET_ADDR_W-1:0] SR_ADDR = SR_RX_FE_BASE   // mapping register
)(
   input  wire                   radio_clk,
   input  wire                   i_rst,
   // settings bus
   input  wire                   i_set_stb,
   input  wire  [SET_ADDR_W-1:0] i_set_addr,
   input  wire  [SET_DATA_W-1:0] i_set_data,
   // sample path, one word per cycle
   input  wire  [SAMP_W-1:0]     i_sample,
   output logic [SAMP_W-1:0]     o_sample
);

   logic [FE_MAP_W-1:0] map_r;
   logic [COMP_W-1:0]   in_i;
   logic [COMP_W-1:0]   in_q;
   logic [COMP_W-1:0]   sw_i;    // after optional swap
   logic [COMP_W-1:0]   sw_q;
   logic [COMP_W-1:0]   out_i;
   logic [COMP_W-1:0]   out_q;

   // negate, clamping the one value with no positive twin
   function automatic logic [COMP_W-1:0] sat_neg(input logic [COMP_W-1:0] x);
      logic [COMP_W-1:0] neg;
      neg = ~x + 1'b1;
      if (x == COMP_MIN)
         neg = COMP_MAX;
      return neg;
   endfunction

   // ----------------------------------------
   // mapping register
   // ----------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
         map_r <= '0;   // straight through
      else if (i_set_stb && (i_set_addr == SR_ADDR))
         map_r <= i_set_data[FE_MAP_W-1:0];
   end

   assign in_i = i_sample[SAMP_W-1 -: COMP_W];
   assign in_q = i_sample[COMP_W-1:0];

   // swap first, then invert per lane
   assign sw_i  = map_r[MAP_SWAP_IQ] ? in_q : in_i;
   assign sw_q  = map_r[MAP_SWAP_IQ] ? in_i : in_q;
   assign out_i = map_r[MAP_INV_I] ? sat_neg(sw_i) : sw_i;
   assign out_q = map_r[MAP_INV_Q] ? sat_neg(sw_q) : sw_q;

   // ----------------------------------------
   // output register
   // ----------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
         o_sample <= '0;
      else
         o_sample <= {out_i, out_q};   // 1 cycle latency
   end

   // mapping in force one edge back governs the word now at the output
   a_inv_saturates : assert property (@(posedge radio_clk) disable iff (i_rst)
      !$past(i_rst) |->
         (!$past(map_r[MAP_INV_I]) || (o_sample[SAMP_W-1 -: COMP_W] != COMP_MIN)) &&
         (!$past(map_r[MAP_INV_Q]) || (o_sample[COMP_W-1:0] != COMP_MIN)));

endmodule

`default_nettype wire

/* design/db_control.sv */
`timescale 1ns/1ps
`default_nettype none

module db_control
   import x300_radio_pkg::*;
(
   input  wire                   radio_clk,
   input  wire                   i_rst,
   // settings bus
   input  wire                   i_set_stb,
   input  wire  [SET_ADDR_W-1:0] i_set_addr,
   input  wire  [SET_DATA_W-1:0] i_set_data,
   // readback bus
   input  wire                   i_rb_stb,
   input  wire  [SET_ADDR_W-1:0] i_rb_addr,
   output logic                  o_rb_stb,
   output logic [RB_DATA_W-1:0]  o_rb_data,
   // run levels for the slot
   input  wire                   i_run_rx,
   input  wire                   i_run_tx,
   // daughterboard gpio
   input  wire  [SAMP_W-1:0]     i_db_gpio_in,
   output logic [SAMP_W-1:0]     o_db_gpio_out,
   output logic [SAMP_W-1:0]     o_db_gpio_ddr,
   output logic [LED_W-1:0]      o_leds,
   // misc words
   input  wire  [SAMP_W-1:0]     i_misc_in,
   output logic [SAMP_W-1:0]     o_misc_out
);

   logic [SAMP_W-1:0] misc_out_r;   // first stage, loaded on write
   logic [SAMP_W-1:0] misc_in_r;
   logic [SAMP_W-1:0] led_word;     // only the low LED_W bits drive pins
   atr_state_t        gpio_state;

   // ----------------------------------------
   // atr controllers
   // ----------------------------------------
   atr_gpio_ctrl #(
      .SR_BASE    (SR_DB_BASE + SR_GPIO_ATR)
   ) u_gpio_atr (
      .radio_clk  (radio_clk),
      .i_rst      (i_rst),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_run_rx   (i_run_rx),
      .i_run_tx   (i_run_tx),
      .o_out      (o_db_gpio_out),
      .o_state    (gpio_state)    // reported on readback
   );

   // same state decode as gpio, so its state output is left open
   atr_gpio_ctrl #(
      .SR_BASE    (SR_DB_BASE + SR_LED_ATR)
   ) u_led_atr (
      .radio_clk  (radio_clk),
      .i_rst      (i_rst),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_run_rx   (i_run_rx),
      .i_run_tx   (i_run_tx),
      .o_out      (led_word),
      .o_state    ()
   );

   assign o_leds = led_word[LED_W-1:0];

   // ----------------------------------------
   // direction and misc registers
   // ----------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
      begin
         o_db_gpio_ddr <= '0;
         misc_out_r    <= '0;
         o_misc_out    <= '0;
         misc_in_r     <= '0;
      end
      else
      begin
         if (i_set_stb && (i_set_addr == SR_DB_BASE + SR_GPIO_DDR))
            o_db_gpio_ddr <= i_set_data;   // visible next cycle
         if (i_set_stb && (i_set_addr == SR_DB_BASE + SR_MISC_OUT))
            misc_out_r <= i_set_data;
         o_misc_out <= misc_out_r;         // second stage toward the pins
         misc_in_r  <= i_misc_in;          // pins into the radio domain
      end
   end

   // ----------------------------------------
   // readback mux
   // ----------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
      begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end
      else
      begin
         o_rb_stb <= i_rb_stb;   // one-cycle answer
         if (i_rb_stb)
         begin
            case (i_rb_addr)
               RB_MISC_IN: o_rb_data <= {{(RB_DATA_W-SAMP_W){1'b0}}, misc_in_r};
               RB_GPIO:    o_rb_data <= {o_db_gpio_ddr, i_db_gpio_in};
               RB_ATR:     o_rb_data <= {{(RB_DATA_W-$bits(atr_state_t)){1'b0}}, gpio_state};
               default:    o_rb_data <= '0;   // unmapped reads as zero
            endcase
         end
         // data holds between requests
      end
   end

   // every request is answered, and nothing else raises the strobe
   a_rb_one_cycle : assert property (@(posedge radio_clk) disable iff (i_rst)
      o_rb_stb == ($past(i_rb_stb) && !$past(i_rst)));

endmodule

`default_nettype wire

/* design/atr_gpio_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module atr_gpio_ctrl
   import x300_radio_pkg::*;
#(
   parameter logic [SET_ADDR_W-1:0] SR_BASE = SR_DB_BASE + SR_GPIO_ATR   // idle word
)(
   input  wire                   radio_clk,
   input  wire                   i_rst,
   // settings bus
   input  wire                   i_set_stb,
   input  wire  [SET_ADDR_W-1:0] i_set_addr,
   input  wire  [SET_DATA_W-1:0] i_set_data,
   // run levels, already or-ed per slot
   input  wire                   i_run_rx,
   input  wire                   i_run_tx,
   output logic [SAMP_W-1:0]     o_out,
   output atr_state_t            o_state
);

   logic [SAMP_W-1:0]     atr_word [ATR_NUM_WORDS];   // indexed by atr_state_t
   logic [SET_ADDR_W-1:0] addr_off;                   // wraps, so any base works
   logic                  word_hit;

   assign addr_off = i_set_addr - SR_BASE;
   assign word_hit = i_set_stb && (addr_off < ATR_NUM_WORDS);

   // ----------------------------------------
   // word bank
   // ----------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
      begin
         for (int k = 0; k < ATR_NUM_WORDS; k++)
         begin
            atr_word[k] <= '0;
         end
      end
      else if (word_hit)
      begin
         atr_word[addr_off[1:0]] <= i_set_data;   // low bits pick the word
      end
   end

   // state straight from the run levels, no register
   always_comb
   begin
      case ({i_run_tx, i_run_rx})
         2'b01:   o_state = ATR_RX;
         2'b10:   o_state = ATR_TX;
         2'b11:   o_state = ATR_FDX;   // both running
         default: o_state = ATR_IDLE;
      endcase
   end

   // ----------------------------------------
   // output select
   // ----------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
         o_out <= '0;
      else
         o_out <= atr_word[o_state];   // one cycle from run change
   end

   // state must resolve to a defined encoding once out of reset
   a_state_legal : assert property (@(posedge radio_clk) disable iff (i_rst)
      !$isunknown(o_state) && (o_state inside {ATR_IDLE, ATR_RX, ATR_TX, ATR_FDX}));

endmodule

`default_nettype wire

/* design/x300_radio_pkg.sv */
`default_nettype none

package x300_radio_pkg;

   // ----------------------------------------
   // slot and channel counts
   // ----------------------------------------
   localparam int NUM_DBOARDS             = 2;
   localparam int NUM_CHANNELS_PER_DBOARD = 2;   // rx channels per slot
   localparam int NUM_CHANNELS            = NUM_DBOARDS * NUM_CHANNELS_PER_DBOARD;

   // ----------------------------------------
   // widths
   // ----------------------------------------
   localparam int SAMP_W        = 32;   // {i, q}, i in the upper half
   localparam int COMP_W        = 16;   // one component, two's complement
   localparam int SET_ADDR_W    = 8;
   localparam int SET_DATA_W    = 32;
   localparam int RB_DATA_W     = 64;
   localparam int LED_W         = 3;    // {rx, txrx_tx, txrx_rx}
   localparam int FE_MAP_W      = 3;    // swap, inv i, inv q
   localparam int ATR_NUM_WORDS = 4;    // idle, rx, tx, fdx

   // full-scale component values
   localparam logic [COMP_W-1:0] COMP_MIN = {1'b1, {(COMP_W-1){1'b0}}};
   localparam logic [COMP_W-1:0] COMP_MAX = {1'b0, {(COMP_W-1){1'b1}}};

   // ----------------------------------------
   // settings bus map
   // ----------------------------------------
   localparam logic [SET_ADDR_W-1:0] SR_DB_BASE  = 8'd160;
   // offsets from SR_DB_BASE
   localparam logic [SET_ADDR_W-1:0] SR_GPIO_ATR = 8'd0;   // 0..3
   localparam logic [SET_ADDR_W-1:0] SR_GPIO_DDR = 8'd4;
   localparam logic [SET_ADDR_W-1:0] SR_LED_ATR  = 8'd5;   // 5..8
   localparam logic [SET_ADDR_W-1:0] SR_MISC_OUT = 8'd9;

   // front end, one register per channel
   localparam logic [SET_ADDR_W-1:0] SR_FE_CHAN_OFFSET = 8'd16;
   localparam logic [SET_ADDR_W-1:0] SR_TX_FE_BASE     = SR_DB_BASE + 8'd48;   // 208
   localparam logic [SET_ADDR_W-1:0] SR_RX_FE_BASE     = SR_DB_BASE + 8'd64;   // 224

   // ----------------------------------------
   // readback map
   // ----------------------------------------
   localparam logic [SET_ADDR_W-1:0] RB_DB_BASE = 8'd16;
   localparam logic [SET_ADDR_W-1:0] RB_MISC_IN = RB_DB_BASE + 8'd0;   // {0, misc in}
   localparam logic [SET_ADDR_W-1:0] RB_GPIO    = RB_DB_BASE + 8'd1;   // {ddr, gpio in}
   localparam logic [SET_ADDR_W-1:0] RB_ATR     = RB_DB_BASE + 8'd2;   // state in [1:0]

   // atr state, encoded as {tx, rx}
   typedef enum logic [1:0] {
      ATR_IDLE = 2'd0,
      ATR_RX   = 2'd1,
      ATR_TX   = 2'd2,
      ATR_FDX  = 2'd3
   } atr_state_t;

   // bit positions in the fe mapping register
   typedef enum logic [1:0] {
      MAP_SWAP_IQ = 2'd0,
      MAP_INV_I   = 2'd1,
      MAP_INV_Q   = 2'd2
   } fe_map_bit_t;

endpackage

`default_nettype wire
